/* ddr_pkg.sv */
`default_nettype none

package ddr_pkg;

    localparam int BANK_BITS    = 3;
    localparam int ROW_BITS     = 14;
    localparam int COL_BITS     = 10;
    localparam int DATA_BITS    = 16;
    localparam int BURST_LENGTH = 8;
    localparam int BYTE_BITS    = $clog2(DATA_BITS / 8);
    localparam int ADDR_BITS    = BANK_BITS + ROW_BITS + COL_BITS + BYTE_BITS;
    localparam int BURST_BITS   = BURST_LENGTH * DATA_BITS;

    localparam logic [15:0] REG_RESET_STATE   = 16'h0000;
    localparam logic [15:0] REG_OVERRIDE_CMD  = 16'h0004;
    localparam logic [15:0] REG_OVERRIDE_ADDR = 16'h0008;

    // CS, RAS, CAS, WE
    typedef enum logic [3:0] {
        CMD_MODE_SET  = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVATE  = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } ddr_cmd_e;

    typedef enum logic [2:0] {
        BS_PRECHARGED,
        BS_ACTIVATE_ROW,
        BS_OP,
        BS_READ,
        BS_READ_END,
        BS_WRITE,
        BS_WRITE_END
    } bank_state_e;

    typedef struct packed {
        logic                 cke;
        ddr_cmd_e             cmd;
        logic [BANK_BITS-1:0] ba;
        logic [ROW_BITS-1:0]  addr;
        logic                 odt;
    } ddr_pin_cmd_t;

    // Address is bank, row, column, byte from the top down
    typedef struct packed {
        logic                  write;
        logic [ADDR_BITS-1:0]  addr;
        logic [BURST_BITS-1:0] data;   // Word 0 in the low bits
    } host_cmd_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [15:0] addr;
        logic [31:0] data;
    } reg_req_t;

endpackage

`default_nettype wire

/* ddr_cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_cmd_queue #(
    parameter int CMD_DEPTH = 4
) (
    input  wire                     ddr_clock_i,
    input  wire                     rst_i,
    input  wire                     push_i,
    input  wire ddr_pkg::host_cmd_t cmd_i,
    input  wire                     pop_i,
    output ddr_pkg::host_cmd_t      head_o,
    output logic                    not_empty_o,
    output logic                    credit_o
);
    import ddr_pkg::*;

    localparam int PTR_BITS = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(CMD_DEPTH + 1);

    host_cmd_t           mem [CMD_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                take;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(CMD_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign take        = pop_i && not_empty_o;
    assign not_empty_o = count != '0;
    assign head_o      = mem[rd_ptr];

    always_ff @(posedge ddr_clock_i) begin
        if (push_i)
            mem[wr_ptr] <= cmd_i;
    end

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= take;   // One credit back per entry taken
            if (push_i)
                wr_ptr <= next_ptr(wr_ptr);
            if (take)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push_i, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* ddr_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_ctrl_regs (
    input  wire                    ddr_clock_i,
    input  wire                    rst_i,
    input  wire ddr_pkg::reg_req_t reg_req_i,
    output logic                   reg_rsp_valid_o,
    output logic [31:0]            reg_rsp_data_o,
    output logic                   bypass_o,
    output logic                   reset_n_o,
    output logic                   phy_reset_n_o,
    output logic                   cke_o,
    output logic                   odt_force_o,
    output logic                   override_valid_o,
    output ddr_pkg::ddr_pin_cmd_t  override_o
);
    import ddr_pkg::*;

    logic [31:0] reset_state;
    logic [31:0] override_addr;
    logic        wr_en;
    logic        rd_en;

    assign wr_en = reg_req_i.valid && reg_req_i.write;
    assign rd_en = reg_req_i.valid && !reg_req_i.write;

    // Reset word layout
    assign reset_n_o     = reset_state[0];
    assign phy_reset_n_o = reset_state[1];
    assign bypass_o      = !reset_state[3];   // Set bit 3 to run the sequencer
    assign odt_force_o   = reset_state[4];
    assign cke_o         = reset_state[5];

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            reset_state      <= '0;
            override_addr    <= '0;
            override_valid_o <= 1'b0;
            reg_rsp_valid_o  <= 1'b0;
        end else begin
            override_valid_o <= wr_en && reg_req_i.addr == REG_OVERRIDE_CMD;
            reg_rsp_valid_o  <= rd_en;
            if (wr_en && reg_req_i.addr == REG_RESET_STATE)
                reset_state <= reg_req_i.data;
            if (wr_en && reg_req_i.addr == REG_OVERRIDE_ADDR)
                override_addr <= reg_req_i.data;
        end
    end

    always_ff @(posedge ddr_clock_i) begin
        if (wr_en && reg_req_i.addr == REG_OVERRIDE_CMD) begin
            override_o.cke  <= reset_state[5];
            override_o.cmd  <= ddr_cmd_e'(reg_req_i.data[3:0]);
            override_o.ba   <= override_addr[31 -: BANK_BITS];   // Bank from the top bits
            override_o.addr <= override_addr[ROW_BITS-1:0];
            override_o.odt  <= reset_state[4];
        end
        if (rd_en) begin
            case (reg_req_i.addr)
                REG_RESET_STATE:   reg_rsp_data_o <= reset_state;
                REG_OVERRIDE_ADDR: reg_rsp_data_o <= override_addr;
                default:           reg_rsp_data_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* ddr_refresh_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_refresh_timer #(
    parameter int T_REFI = 3120
) (
    input  wire  ddr_clock_i,
    input  wire  rst_i,
    input  wire  bypass_i,
    input  wire  refresh_ack_i,
    output logic refresh_req_o
);

    localparam int CNT_BITS = $clog2(T_REFI + 1);

    logic [CNT_BITS-1:0] count;

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            count         <= CNT_BITS'(T_REFI - 1);
            refresh_req_o <= 1'b0;
        end else begin
            if (refresh_ack_i)
                refresh_req_o <= 1'b0;
            if (count == '0) begin
                count         <= CNT_BITS'(T_REFI - 1);
                refresh_req_o <= 1'b1;   // Sticky until acknowledged
            end else if (!bypass_i) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* ddr_bank_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_bank_fsm #(
    parameter int T_RCD          = 6,
    parameter int T_RP           = 6,
    parameter int T_RFC          = 44,
    parameter int CAS_READ_LAT   = 5,
    parameter int CAS_WRITE_LAT  = 5,
    parameter int WRITE_RECOVERY = 6
) (
    input  wire                        ddr_clock_i,
    input  wire                        rst_i,
    input  wire                        bypass_i,
    input  wire                        cke_i,
    input  wire                        odt_force_i,
    input  wire                        override_valid_i,
    input  wire ddr_pkg::ddr_pin_cmd_t override_i,
    input  wire                        refresh_req_i,
    output logic                       refresh_ack_o,
    input  wire                        cmd_valid_i,
    input  wire ddr_pkg::host_cmd_t    cmd_i,
    output logic                       pop_o,
    output ddr_pkg::ddr_pin_cmd_t      pin_o,
    output logic                       load_write_o,
    output logic                       capture_read_o,
    output logic                       data_write_o
);
    import ddr_pkg::*;

    localparam int HALF_BURST = BURST_LENGTH / 2;

    bank_state_e          state;
    logic [7:0]           wait_cnt;
    logic                 wait_zero;
    logic                 idle;
    logic                 odt_write;
    logic                 cur_write;
    logic [ADDR_BITS-1:0] cur_addr;
    logic [BANK_BITS-1:0] cur_bank;
    logic [ROW_BITS-1:0]  cur_row;
    logic [COL_BITS-1:0]  cur_col;

    // Zero flag and count so the FSM acts again after this many cycles
    function automatic logic [8:0] wait_for(input int cycles);
        return {cycles <= 1, 8'(cycles - 1)};
    endfunction

    assign idle           = state == BS_PRECHARGED && wait_zero && !bypass_i;
    assign refresh_ack_o  = idle && refresh_req_i;   // Refresh beats a queued command
    assign pop_o          = idle && !refresh_req_i && cmd_valid_i;
    assign load_write_o   = pop_o && cmd_i.write;
    assign capture_read_o = state == BS_READ_END && wait_zero;

    assign cur_bank = cur_addr[ADDR_BITS-1 -: BANK_BITS];
    assign cur_row  = cur_addr[BYTE_BITS+COL_BITS +: ROW_BITS];
    assign cur_col  = cur_addr[BYTE_BITS +: COL_BITS];

    always_ff @(posedge ddr_clock_i) begin
        if (pop_o) begin
            cur_write <= cmd_i.write;
            cur_addr  <= cmd_i.addr;
        end
    end

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            state        <= BS_PRECHARGED;
            wait_cnt     <= '0;
            wait_zero    <= 1'b1;
            odt_write    <= 1'b0;
            data_write_o <= 1'b0;
            pin_o        <= '{cke: 1'b0, cmd: CMD_NOP, ba: '0, addr: '0, odt: 1'b0};
        end else begin
            if (!wait_zero) begin
                wait_cnt  <= wait_cnt - 8'd1;
                wait_zero <= wait_cnt == 8'd1;
            end

            pin_o <= '{cke: cke_i, cmd: CMD_NOP, ba: '0, addr: '0,
                       odt: odt_force_i || odt_write};

            if (wait_zero) begin
                case (state)
                    BS_PRECHARGED: begin
                        if (refresh_ack_o) begin
                            pin_o.cmd              <= CMD_REFRESH;
                            {wait_zero, wait_cnt} <= wait_for(T_RFC);
                        end else if (pop_o) begin
                            state <= BS_ACTIVATE_ROW;
                        end
                    end
                    BS_ACTIVATE_ROW: begin
                        pin_o.cmd              <= CMD_ACTIVATE;
                        pin_o.ba               <= cur_bank;
                        pin_o.addr             <= cur_row;
                        state                  <= BS_OP;
                        {wait_zero, wait_cnt} <= wait_for(T_RCD);
                    end
                    BS_OP: begin
                        pin_o.ba   <= cur_bank;
                        pin_o.addr <= ROW_BITS'({1'b1, cur_col});   // A10 auto-precharge
                        if (cur_write) begin
                            pin_o.cmd              <= CMD_WRITE;
                            pin_o.odt              <= 1'b1;
                            odt_write              <= 1'b1;
                            state                  <= BS_WRITE;
                            {wait_zero, wait_cnt} <= wait_for(CAS_WRITE_LAT);
                        end else begin
                            pin_o.cmd              <= CMD_READ;
                            state                  <= BS_READ;
                            {wait_zero, wait_cnt} <= wait_for(CAS_READ_LAT + 1);
                        end
                    end
                    BS_WRITE: begin
                        data_write_o           <= 1'b1;
                        state                  <= BS_WRITE_END;
                        {wait_zero, wait_cnt} <= wait_for(HALF_BURST);
                    end
                    BS_WRITE_END: begin
                        data_write_o           <= 1'b0;
                        odt_write              <= 1'b0;
                        state                  <= BS_PRECHARGED;
                        {wait_zero, wait_cnt} <= wait_for(T_RP + WRITE_RECOVERY);
                    end
                    BS_READ: begin
                        state                  <= BS_READ_END;
                        {wait_zero, wait_cnt} <= wait_for(HALF_BURST);
                    end
                    BS_READ_END: begin
                        state                  <= BS_PRECHARGED;   // Burst captured now
                        {wait_zero, wait_cnt} <= wait_for(T_RP);
                    end
                    default: state <= BS_PRECHARGED;
                endcase
            end

            // Raw host command takes the pins in bypass
            if (bypass_i && override_valid_i)
                pin_o <= override_i;
        end
    end

endmodule

`default_nettype wire

/* ddr_burst_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_burst_datapath (
    input  wire                               ddr_clock_i,
    input  wire                               rst_i,
    input  wire                               load_write_i,
    input  wire                               data_write_i,
    input  wire [ddr_pkg::BURST_BITS-1:0]     write_data_i,
    input  wire                               capture_read_i,
    input  wire [ddr_pkg::BURST_BITS-1:0]     dq_i,
    output logic [2*ddr_pkg::DATA_BITS-1:0]   dq_o,
    output logic                              rsp_valid_o,
    output logic [ddr_pkg::BURST_BITS-1:0]    rsp_data_o
);
    import ddr_pkg::*;

    localparam int HALF_BITS = BURST_BITS / 2;

    logic [HALF_BITS-1:0] even_sr;
    logic [HALF_BITS-1:0] odd_sr;

    // Every second word of a burst, starting at word first
    function automatic logic [HALF_BITS-1:0] pick_words(input logic [BURST_BITS-1:0] burst,
                                                        input int first);
        logic [HALF_BITS-1:0] half;
        for (int i = 0; i < BURST_LENGTH / 2; i++)
            half[i*DATA_BITS +: DATA_BITS] = burst[(2*i+first)*DATA_BITS +: DATA_BITS];
        return half;
    endfunction

    always_ff @(posedge ddr_clock_i) begin
        if (load_write_i) begin
            even_sr <= pick_words(write_data_i, 0);
            odd_sr  <= pick_words(write_data_i, 1);
        end else if (data_write_i) begin
            even_sr <= even_sr >> DATA_BITS;   // Next pair
            odd_sr  <= odd_sr >> DATA_BITS;
        end
    end

    assign dq_o = {odd_sr[DATA_BITS-1:0], even_sr[DATA_BITS-1:0]};

    always_ff @(posedge ddr_clock_i) begin
        if (capture_read_i)
            rsp_data_o <= dq_i;
    end

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i)
            rsp_valid_o <= 1'b0;
        else
            rsp_valid_o <= capture_read_i;
    end

endmodule

`default_nettype wire

/* ddr_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_ctrl_top #(
    parameter int T_RCD          = 6,
    parameter int T_RP           = 6,
    parameter int T_RFC          = 44,
    parameter int T_REFI         = 3120,
    parameter int CAS_READ_LAT   = 5,
    parameter int CAS_WRITE_LAT  = 5,
    parameter int WRITE_RECOVERY = 6,
    parameter int CMD_DEPTH      = 4
) (
    input  wire                             ddr_clock_i,
    input  wire                             rst_i,
    input  wire                             host_cmd_valid_i,
    input  wire ddr_pkg::host_cmd_t         host_cmd_i,
    output logic                            credit_o,
    output logic                            rsp_valid_o,
    output logic [ddr_pkg::BURST_BITS-1:0]  rsp_data_o,
    input  wire ddr_pkg::reg_req_t          reg_req_i,
    output logic                            reg_rsp_valid_o,
    output logic [31:0]                     reg_rsp_data_o,
    output logic                            ddr_reset_n_o,
    output logic                            ddr_phy_reset_n_o,
    output ddr_pkg::ddr_pin_cmd_t           ddr3_pin_o,
    output logic [2*ddr_pkg::DATA_BITS-1:0] ddr3_dq_o,
    input  wire [ddr_pkg::BURST_BITS-1:0]   ddr3_dq_i,
    output logic                            data_write_o
);
    import ddr_pkg::*;

    host_cmd_t    head;
    ddr_pin_cmd_t override;
    logic         head_valid;
    logic         pop;
    logic         bypass;
    logic         cke;
    logic         odt_force;
    logic         override_valid;
    logic         refresh_req;
    logic         refresh_ack;
    logic         load_write;
    logic         capture_read;

    ddr_cmd_queue #(
        .CMD_DEPTH(CMD_DEPTH)
    ) cmd_queue_i (
        .ddr_clock_i(ddr_clock_i),
        .rst_i(rst_i),
        .push_i(host_cmd_valid_i),
        .cmd_i(host_cmd_i),
        .pop_i(pop),
        .head_o(head),
        .not_empty_o(head_valid),
        .credit_o(credit_o)
    );

    ddr_ctrl_regs ctrl_regs_i (
        .ddr_clock_i(ddr_clock_i),
        .rst_i(rst_i),
        .reg_req_i(reg_req_i),
        .reg_rsp_valid_o(reg_rsp_valid_o),
        .reg_rsp_data_o(reg_rsp_data_o),
        .bypass_o(bypass),
        .reset_n_o(ddr_reset_n_o),
        .phy_reset_n_o(ddr_phy_reset_n_o),
        .cke_o(cke),
        .odt_force_o(odt_force),
        .override_valid_o(override_valid),
        .override_o(override)
    );

    ddr_refresh_timer #(
        .T_REFI(T_REFI)
    ) refresh_timer_i (
        .ddr_clock_i(ddr_clock_i),
        .rst_i(rst_i),
        .bypass_i(bypass),
        .refresh_ack_i(refresh_ack),
        .refresh_req_o(refresh_req)
    );

    ddr_bank_fsm #(
        .T_RCD(T_RCD),
        .T_RP(T_RP),
        .T_RFC(T_RFC),
        .CAS_READ_LAT(CAS_READ_LAT),
        .CAS_WRITE_LAT(CAS_WRITE_LAT),
        .WRITE_RECOVERY(WRITE_RECOVERY)
    ) bank_fsm_i (
        .ddr_clock_i(ddr_clock_i),
        .rst_i(rst_i),
        .bypass_i(bypass),
        .cke_i(cke),
        .odt_force_i(odt_force),
        .override_valid_i(override_valid),
        .override_i(override),
        .refresh_req_i(refresh_req),
        .refresh_ack_o(refresh_ack),
        .cmd_valid_i(head_valid),
        .cmd_i(head),
        .pop_o(pop),
        .pin_o(ddr3_pin_o),
        .load_write_o(load_write),
        .capture_read_o(capture_read),
        .data_write_o(data_write_o)
    );

    // Write burst is taken from the queue head as it is popped
    ddr_burst_datapath burst_datapath_i (
        .ddr_clock_i(ddr_clock_i),
        .rst_i(rst_i),
        .load_write_i(load_write),
        .data_write_i(data_write_o),
        .write_data_i(head.data),
        .capture_read_i(capture_read),
        .dq_i(ddr3_dq_i),
        .dq_o(ddr3_dq_o),
        .rsp_valid_o(rsp_valid_o),
        .rsp_data_o(rsp_data_o)
    );

endmodule

`default_nettype wire

/* tb_ddr_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_model (
    input  wire                               ddr_clock_i,
    input  wire ddr_pkg::ddr_pin_cmd_t        pin_i,
    input  wire                               data_write_i,
    input  wire [2*ddr_pkg::DATA_BITS-1:0]    dq_i,
    output logic [ddr_pkg::BURST_BITS-1:0]    dq_o
);
    import ddr_pkg::*;

    localparam int KEY_BITS = BANK_BITS + ROW_BITS + COL_BITS;

    logic [BURST_BITS-1:0] store [logic [KEY_BITS-1:0]];
    logic [BANK_BITS-1:0]  bank;
    logic [ROW_BITS-1:0]   row;
    logic [KEY_BITS-1:0]   wr_key;
    logic [KEY_BITS-1:0]   rd_key;
    logic [BURST_BITS-1:0] wr_burst;
    int                    pair_idx;

    initial begin
        dq_o     = '0;
        bank     = '0;
        row      = '0;
        wr_key   = '0;
        wr_burst = '0;
        pair_idx = 0;
    end

    always @(posedge ddr_clock_i) begin
        case (pin_i.cmd)
            CMD_ACTIVATE: begin
                bank = pin_i.ba;
                row  = pin_i.addr;
            end
            CMD_WRITE: begin
                wr_key   = {bank, row, pin_i.addr[COL_BITS-1:0]};
                pair_idx = 0;
            end
            CMD_READ: begin
                rd_key = {bank, row, pin_i.addr[COL_BITS-1:0]};
                dq_o <= store.exists(rd_key) ? store[rd_key] : '0;   // Held until next READ
            end
            default: ;
        endcase
        if (data_write_i) begin
            wr_burst[pair_idx*2*DATA_BITS +: 2*DATA_BITS] = dq_i;   // Pairs in burst order
            pair_idx = pair_idx + 1;
            if (pair_idx == BURST_LENGTH / 2)
                store[wr_key] = wr_burst;
        end
    end

endmodule

`default_nettype wire

/* tb_ddr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_ctrl;
    import ddr_pkg::*;

    localparam int T_RCD          = 2;
    localparam int T_RP           = 3;
    localparam int T_RFC          = 6;
    localparam int T_REFI         = 200;
    localparam int CAS_READ_LAT   = 5;
    localparam int CAS_WRITE_LAT  = 5;
    localparam int WRITE_RECOVERY = 2;
    localparam int CMD_DEPTH      = 2;
    localparam int MAX_OP = T_RFC + 1 + T_RCD + CAS_WRITE_LAT + 1 + BURST_LENGTH / 2
                            + T_RP + WRITE_RECOVERY + 4;

    logic                      ddr_clock = 1'b0;
    logic                      rst_i;
    logic                      host_cmd_valid_i;
    host_cmd_t                 host_cmd_i;
    reg_req_t                  reg_req_i;
    logic                      credit_o;
    logic                      rsp_valid_o;
    logic                      reg_rsp_valid_o;
    logic                      data_write_o;
    logic [BURST_BITS-1:0]     rsp_data_o;
    logic [BURST_BITS-1:0]     ddr3_dq_i;
    logic [31:0]               reg_rsp_data_o;
    logic                      ddr_reset_n_o;
    logic                      ddr_phy_reset_n_o;
    ddr_pin_cmd_t              ddr3_pin_o;
    logic [2*DATA_BITS-1:0]    ddr3_dq_o;

    logic [31:0]               stim [0:95];
    logic [BURST_BITS-1:0]     sb [logic [ADDR_BITS-1:0]];   // Last data written per address
    logic [BURST_BITS-1:0]     exp_q [$];
    logic [15:0]               lfsr = 16'd43;
    logic [31:0]               reg0_val = '0;
    logic [31:0]               ovr_addr = '0;
    logic                      bypass_tb = 1'b1;
    logic                      in_op = 1'b0;
    logic                      write_seen = 1'b0;
    int                        issued = 0;
    int                        returned = 0;
    int                        num_ops = 0;
    int                        refresh_seen = 0;
    int                        cycles = 0;
    int                        limit = 100000;
    int                        act_cycle = 0;
    int                        wr_cycle = 0;
    int                        dw_rise = 0;
    int                        since_refresh = 0;

    always #20 ddr_clock = ~ddr_clock;

    ddr_ctrl_top #(
        .T_RCD(T_RCD), .T_RP(T_RP), .T_RFC(T_RFC), .T_REFI(T_REFI),
        .CAS_READ_LAT(CAS_READ_LAT), .CAS_WRITE_LAT(CAS_WRITE_LAT),
        .WRITE_RECOVERY(WRITE_RECOVERY), .CMD_DEPTH(CMD_DEPTH)
    ) dut_i (
        .ddr_clock_i(ddr_clock), .rst_i(rst_i),
        .host_cmd_valid_i(host_cmd_valid_i), .host_cmd_i(host_cmd_i), .credit_o(credit_o),
        .rsp_valid_o(rsp_valid_o), .rsp_data_o(rsp_data_o),
        .reg_req_i(reg_req_i), .reg_rsp_valid_o(reg_rsp_valid_o),
        .reg_rsp_data_o(reg_rsp_data_o), .ddr_reset_n_o(ddr_reset_n_o),
        .ddr_phy_reset_n_o(ddr_phy_reset_n_o), .ddr3_pin_o(ddr3_pin_o),
        .ddr3_dq_o(ddr3_dq_o), .ddr3_dq_i(ddr3_dq_i), .data_write_o(data_write_o)
    );

    tb_ddr_model model_i (
        .ddr_clock_i(ddr_clock), .pin_i(ddr3_pin_o), .data_write_i(data_write_o),
        .dq_i(ddr3_dq_o), .dq_o(ddr3_dq_i)
    );

    task automatic check(input string name, input logic [BURST_BITS-1:0] expected,
                         input logic [BURST_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [BURST_BITS-1:0] random_burst();
        logic [BURST_BITS-1:0] b;
        for (int i = 0; i < BURST_BITS; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
        return b;
    endfunction

    task automatic reg_access(input logic wr, input logic [15:0] addr, input logic [31:0] data);
        @(posedge ddr_clock);
        reg_req_i <= '{valid: 1'b1, write: wr, addr: addr, data: data};
        @(posedge ddr_clock);
        reg_req_i.valid <= 1'b0;
    endtask

    task automatic send_host(input logic wr, input logic [ADDR_BITS-1:0] addr,
                             input logic [BURST_BITS-1:0] data);
        @(posedge ddr_clock);
        while (issued - returned >= CMD_DEPTH)
            @(posedge ddr_clock);   // Out of credits
        host_cmd_valid_i <= 1'b1;
        host_cmd_i       <= '{write: wr, addr: addr, data: data};
        issued++;
        @(posedge ddr_clock);
        host_cmd_valid_i <= 1'b0;
    endtask

    task automatic drain();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge ddr_clock);
            if (issued == returned && exp_q.size() == 0 && !in_op)
                quiet++;
            else
                quiet = 0;
        end
    endtask

    always @(posedge ddr_clock) begin
        cycles++;
        if (cycles > limit) begin
            $display("TIMEOUT: run did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    // Pin, credit and response monitor
    always @(negedge ddr_clock) begin
        if (!rst_i) begin
            if (credit_o)
                returned++;
            check("credit without command", 1, returned <= issued);
            if (ddr3_pin_o.cmd == CMD_ACTIVATE) begin
                act_cycle = cycles;
                in_op = 1'b1;
            end
            if (ddr3_pin_o.cmd == CMD_WRITE || ddr3_pin_o.cmd == CMD_READ)
                check("ACTIVATE to column command", T_RCD, cycles - act_cycle);
            if (ddr3_pin_o.cmd == CMD_WRITE) begin
                wr_cycle = cycles;
                check("odt at write", 1, ddr3_pin_o.odt);
            end
            if (data_write_o && !write_seen) begin
                dw_rise = cycles;
                check("write data latency", CAS_WRITE_LAT, cycles - wr_cycle);
            end
            if (write_seen && !data_write_o) begin
                check("write burst length", BURST_LENGTH / 2, cycles - dw_rise);
                in_op = 1'b0;   // Write burst done
            end
            write_seen = data_write_o;
            if (ddr3_pin_o.cmd == CMD_REFRESH) begin
                check("refresh outside burst", 0, in_op);
                refresh_seen++;
                since_refresh = 0;
            end else if (!bypass_tb) begin
                since_refresh++;
                check("refresh interval", 1, since_refresh <= T_REFI + MAX_OP);
            end
            if (rsp_valid_o) begin
                check("response expected", 1, exp_q.size() > 0);
                check("read response", exp_q.pop_front(), rsp_data_o);
                in_op = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] seed;
        logic [BURST_BITS-1:0] data;
        rst_i            = 1'b1;
        host_cmd_valid_i = 1'b0;
        host_cmd_i       = '0;
        reg_req_i        = '0;
        for (int i = 0; i < 96; i++)
            stim[i] = '0;
        $readmemh("ddr_stim.txt", stim);
        while (num_ops < 32 && stim[3*num_ops] != 0)
            num_ops++;
        limit = 4 * (num_ops * 40 + T_REFI);

        repeat (2) @(posedge ddr_clock);
        rst_i <= 1'b0;
        @(negedge ddr_clock);
        check("pin NOP after reset", CMD_NOP, ddr3_pin_o.cmd);
        check("cke after reset", 0, ddr3_pin_o.cke);

        for (int n = 0; n < num_ops; n++) begin
            op   = stim[3*n];
            addr = stim[3*n+1];
            seed = stim[3*n+2];
            case (op)
                1: begin
                    reg_access(1'b1, addr[15:0], seed);
                    if (addr[15:0] == REG_RESET_STATE) begin
                        reg0_val  = seed;
                        bypass_tb = !seed[3];
                        @(negedge ddr_clock);
                        check("ddr_reset_n", seed[0], ddr_reset_n_o);
                        check("ddr_phy_reset_n", seed[1], ddr_phy_reset_n_o);
                    end else if (addr[15:0] == REG_OVERRIDE_ADDR) begin
                        ovr_addr = seed;
                    end
                end
                2: begin
                    reg_access(1'b0, addr[15:0], '0);
                    @(negedge ddr_clock);   // Answer one cycle after the request
                    check("register read valid", 1, reg_rsp_valid_o);
                    check("register read-back", seed, reg_rsp_data_o);
                end
                3: begin
                    data = random_burst() ^ {(BURST_LENGTH){seed[15:0]}};
                    sb[addr[ADDR_BITS-1:0]] = data;
                    send_host(1'b1, addr[ADDR_BITS-1:0], data);
                end
                4: begin
                    check("read of written address", 1, sb.exists(addr[ADDR_BITS-1:0]));
                    exp_q.push_back(sb[addr[ADDR_BITS-1:0]]);
                    send_host(1'b0, addr[ADDR_BITS-1:0], '0);
                end
                5: drain();
                6: begin
                    reg_access(1'b1, REG_OVERRIDE_CMD, seed);   // Request ends one edge in
                    @(posedge ddr_clock);
                    @(negedge ddr_clock);
                    check("override cmd", seed[3:0], ddr3_pin_o.cmd);
                    check("override addr", ovr_addr[ROW_BITS-1:0], ddr3_pin_o.addr);
                    check("override bank", ovr_addr[31 -: BANK_BITS], ddr3_pin_o.ba);
                    check("override cke", reg0_val[5], ddr3_pin_o.cke);
                    check("queued while bypassed", 0, returned);
                end
                7: repeat (seed) @(posedge ddr_clock);
                default: check("known stimulus op", 0, op);
            endcase
        end

        drain();
        check("credits returned", issued, returned);
        check("refresh seen", 1, refresh_seen > 0);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* ddr_stim.txt */
// op addr seed: 1 reg write, 2 reg read check, 3 host write, 4 host read,
// 5 drain, 6 override command (seed = cmd), 7 idle (seed = cycles), 0 end
1 00000000 00000023
2 00000000 00000023
3 00010020 0000a5a5
1 00000008 40000123
2 00000008 40000123
6 00000000 00000000
1 00000000 0000002b
5 00000000 00000000
3 02a04010 00001234
3 05c08100 0000beef
4 00010020 00000000
4 02a04010 00000000
4 05c08100 00000000
3 02a04010 00005a5a
4 02a04010 00000000
5 00000000 00000000
7 00000000 0000012c
4 05c08100 00000000
5 00000000 00000000
0 00000000 00000000

/* sources.f */
ddr_pkg.sv
ddr_cmd_queue.sv
ddr_ctrl_regs.sv
ddr_refresh_timer.sv
ddr_bank_fsm.sv
ddr_burst_datapath.sv
ddr_ctrl_top.sv
tb_ddr_model.sv
tb_ddr_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ddr_ctrl
RTL_TOP   ?= ddr_ctrl_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
